//--- compile.f
common/bpi_pkg.sv
fifo/bpi_word_fifo.sv
parser/bpi_cmd_parser.sv
sequencer/bpi_bus_sequencer.sv
source/bpi_status_reg.sv
source/bpi_ctrl.sv
verif/tb_clock_gen.sv
verif/bpi_ctrl_assert.sv
verif/bpi_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module bpi_ctrl_tb &&
./obj_dir/Vbpi_ctrl_tb | tee /dev/stderr | grep -q "All tests passed!" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- verif/bpi_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bpi_ctrl_tb
  import bpi_pkg::*;
;

  localparam int n_entries   = 6;
  localparam int cycle_limit = n_entries * 3000 + 2000;  // Generous per entry

  logic         CLK;
  logic         local_rst;
  word_t        cmd_data;
  logic         cmd_we;
  logic         rbk_re;
  logic         parse_enable;
  logic         parse_disable;
  word_t        rbk_data;
  fifo_count_t  rbk_wrd_cnt;
  word_t        bpi_status;
  logic         bus_busy;
  logic         bus_load_data;
  word_t        bus_data_from;
  logic         bus_execute;
  bus_op_t      bus_op;
  flash_addr_t  bus_addr;
  word_t        bus_data_to;

  // Stimulus and expected values, one row per entry
  int           tbl_nw [n_entries];
  word_t        tbl_w  [n_entries][4];
  int           tbl_nc [n_entries];
  bus_op_t      tbl_cop[n_entries][6];
  flash_addr_t  tbl_ca [n_entries][6];
  word_t        tbl_cd [n_entries][6];
  int           tbl_nr [n_entries];
  word_t        tbl_r  [n_entries][4];
  word_t        tbl_st [n_entries];
  bit           tbl_hold[n_entries];  // Write while parsing disabled
  bit           tbl_err [n_entries];  // PROM reports erase error
  bit           tbl_rde [n_entries];  // Read empty readback FIFO first

  bus_op_t      seen_op[$];
  flash_addr_t  seen_addr[$];
  word_t        seen_data[$];

  // PROM model state
  int           busy_left;
  bit           stat_mode;
  bit           prog_next;
  bit           read_pending;
  bit           erase_err;
  int           polls;
  word_t        read_word;
  int           cycle_cnt;

  tb_clock_gen u_clk (.CLK(CLK), .local_rst(local_rst));

  bpi_ctrl u_dut (
    .CLK           (CLK),
    .local_rst     (local_rst),
    .cmd_data      (cmd_data),
    .cmd_we        (cmd_we),
    .rbk_re        (rbk_re),
    .parse_enable  (parse_enable),
    .parse_disable (parse_disable),
    .rbk_data      (rbk_data),
    .rbk_wrd_cnt   (rbk_wrd_cnt),
    .bpi_status    (bpi_status),
    .bus_busy      (bus_busy),
    .bus_load_data (bus_load_data),
    .bus_data_from (bus_data_from),
    .bus_execute   (bus_execute),
    .bus_op        (bus_op),
    .bus_addr      (bus_addr),
    .bus_data_to   (bus_data_to)
  );

  function automatic word_t array_word(input flash_addr_t a);
    return a[15:0] ^ 16'h5A5A;  // Array contents of the PROM model
  endfunction

  task automatic add_word(input int e, input word_t w);
    tbl_w[e][tbl_nw[e]] = w;
    tbl_nw[e]++;
  endtask

  task automatic add_cycle(input int e, input bus_op_t op, input flash_addr_t a, input word_t d);
    tbl_cop[e][tbl_nc[e]] = op;
    tbl_ca[e][tbl_nc[e]]  = a;
    tbl_cd[e][tbl_nc[e]]  = d;
    tbl_nc[e]++;
  endtask

  task automatic add_rbk(input int e, input word_t w);
    tbl_r[e][tbl_nr[e]] = w;
    tbl_nr[e]++;
  endtask

  task automatic add_polls(input int e, input flash_addr_t bank);
    for (int i = 0; i < 3; i++)
      add_cycle(e, bus_op_read, bank, 16'h0000);  // Two busy polls, then ready
  endtask

  task automatic build_table();
    for (int e = 0; e < n_entries; e++)
    begin
      tbl_nw[e]   = 0;
      tbl_nc[e]   = 0;
      tbl_nr[e]   = 0;
      tbl_hold[e] = 0;
      tbl_err[e]  = 0;
      tbl_rde[e]  = 0;
    end
    // Read_Array held back until parsing is enabled
    tbl_hold[0] = 1;
    add_word(0, 16'h0005);
    add_cycle(0, bus_op_write, 23'h000000, read_array_code);
    tbl_st[0] = 16'h8800;
    // Load_Address 0x123456, Read_n of four words
    add_word(1, 16'h0257);
    add_word(1, 16'h3456);
    add_word(1, 16'h0064);
    for (int i = 0; i < 4; i++)
    begin
      add_cycle(1, bus_op_read, 23'h123456 + i, 16'h0000);
      add_rbk(1, array_word(23'h123456 + i));
    end
    tbl_st[1] = 16'h0800;
    // Program 0xBEEF at 0x120100
    add_word(2, 16'h0257);
    add_word(2, 16'h0100);
    add_word(2, 16'h000B);
    add_word(2, 16'hBEEF);
    add_cycle(2, bus_op_write, 23'h120100, program_setup_code);
    add_cycle(2, bus_op_write, 23'h120100, 16'hBEEF);
    add_polls(2, 23'h100000);
    tbl_st[2] = 16'h8880;
    // Erase in main block region
    add_word(3, 16'h0477);
    add_word(3, 16'h4567);
    add_word(3, 16'h000A);
    add_cycle(3, bus_op_write, 23'h230000, erase_setup_code);
    add_cycle(3, bus_op_write, 23'h230000, confirm_code);
    add_polls(3, 23'h200000);
    tbl_st[3] = 16'h8880;
    // Erase in parameter region, PROM flags an error
    tbl_err[4] = 1;
    add_word(4, 16'h0FF7);
    add_word(4, 16'h9ABC);
    add_word(4, 16'h000A);
    add_cycle(4, bus_op_write, 23'h7F8000, erase_setup_code);
    add_cycle(4, bus_op_write, 23'h7F8000, confirm_code);
    add_polls(4, 23'h780000);
    tbl_st[4] = 16'h88A0;
    // Underflow then Clr_BPI_Status
    tbl_rde[5] = 1;
    add_word(5, 16'h001C);
    tbl_st[5] = 16'h8880;
  endtask

  //////////////////////////////////////////////////
  // PROM bus model and monitor
  //////////////////////////////////////////////////
  always @(posedge CLK)
  begin
    if (bus_execute)
    begin
      seen_op.push_back(bus_op);
      seen_addr.push_back(bus_addr);
      seen_data.push_back(bus_data_to);
      if (bus_op == bus_op_write)
      begin
        polls        = 0;
        read_pending = 0;
        if (prog_next)
          prog_next = 0;  // Program data word
        else if (bus_data_to == read_array_code)
          stat_mode = 0;
        else
        begin
          stat_mode = 1;
          prog_next = (bus_data_to == program_setup_code);
        end
      end
      else
      begin
        read_pending = 1;
        if (stat_mode)
        begin
          if (polls < 2)
            read_word = 16'h0000;
          else
            read_word = erase_err ? 16'h00A0 : 16'h0080;
          polls++;
        end
        else
          read_word = array_word(bus_addr);
      end
      busy_left = 1 + ($urandom % 4);
    end
    else if (busy_left > 0)
      busy_left--;
    #2;
    bus_busy      = (busy_left > 0);
    bus_load_data = read_pending && (busy_left == 1);  // Data in last busy cycle
    bus_data_from = bus_load_data ? read_word : 16'h0000;
    if (bus_load_data)
      read_pending = 0;
  end

  always @(posedge CLK)
  begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the DUT did not finish the tests", cycle_cnt);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // Command FIFO empty and bus quiet for 20 cycles
  task automatic wait_quiet();
    int idle;
    idle = 0;
    while (idle < 20)
    begin
      @(negedge CLK);
      if (bus_execute || bus_busy || !bpi_status[11])
        idle = 0;
      else
        idle++;
    end
  endtask

  task automatic pulse_read();
    @(posedge CLK);
    #2 rbk_re = 1'b1;
    @(posedge CLK);
    #2 rbk_re = 1'b0;
  endtask

  task automatic run_entry(input int e);
    seen_op.delete();
    seen_addr.delete();
    seen_data.delete();
    erase_err = tbl_err[e];
    if (tbl_rde[e])
    begin
      pulse_read();
      repeat (2) @(negedge CLK);
      assert (bpi_status[13] && bpi_status[5])
      else
      begin
        $display("FAIL %0t: entry %0d underflow not flagged, status %h", $time, e, bpi_status);
        $display("Test failures found");
        $fatal(1, "check failed");
      end
    end
    for (int i = 0; i < tbl_nw[e]; i++)
    begin
      @(posedge CLK);
      #2;
      cmd_data = tbl_w[e][i];
      cmd_we   = 1'b1;
    end
    @(posedge CLK);
    #2 cmd_we = 1'b0;
    if (tbl_hold[e])
    begin
      repeat (10) @(negedge CLK);
      assert ((seen_op.size() == 0) && !bpi_status[11])
      else
      begin
        $display("FAIL %0t: entry %0d ran while parsing disabled", $time, e);
        $display("Test failures found");
        $fatal(1, "check failed");
      end
      @(posedge CLK);
      #2 parse_enable = 1'b1;
      @(posedge CLK);
      #2 parse_enable = 1'b0;
    end
    wait_quiet();
    assert (seen_op.size() == tbl_nc[e])
    else
    begin
      $display("FAIL %0t: entry %0d saw %0d bus cycles, expected %0d",
               $time, e, seen_op.size(), tbl_nc[e]);
      $display("Test failures found");
      $fatal(1, "check failed");
    end
    for (int i = 0; i < tbl_nc[e]; i++)
    begin
      assert ((seen_op[i] == tbl_cop[e][i]) && (seen_addr[i] == tbl_ca[e][i]) &&
              ((tbl_cop[e][i] == bus_op_read) || (seen_data[i] == tbl_cd[e][i])))
      else
      begin
        $display("FAIL %0t: entry %0d cycle %0d got op %b addr %h data %h", $time, e, i,
                 seen_op[i], seen_addr[i], seen_data[i]);
        $display("Test failures found");
        $fatal(1, "check failed");
      end
    end
    assert ((bpi_status == tbl_st[e]) && (rbk_wrd_cnt == fifo_count_t'(tbl_nr[e])))
    else
    begin
      $display("FAIL %0t: entry %0d status %h count %0d, expected %h and %0d", $time, e,
               bpi_status, rbk_wrd_cnt, tbl_st[e], tbl_nr[e]);
      $display("Test failures found");
      $fatal(1, "check failed");
    end
    for (int i = 0; i < tbl_nr[e]; i++)
    begin
      @(negedge CLK);
      assert (rbk_data == tbl_r[e][i])
      else
      begin
        $display("FAIL %0t: entry %0d readback %0d is %h, expected %h", $time, e, i,
                 rbk_data, tbl_r[e][i]);
        $display("Test failures found");
        $fatal(1, "check failed");
      end
      pulse_read();
    end
  endtask

  initial
  begin
    cmd_data      = '0;
    cmd_we        = 1'b0;
    rbk_re        = 1'b0;
    parse_enable  = 1'b0;
    parse_disable = 1'b0;
    bus_busy      = 1'b0;
    bus_load_data = 1'b0;
    bus_data_from = '0;
    busy_left     = 0;
    stat_mode     = 0;
    prog_next     = 0;
    read_pending  = 0;
    erase_err     = 0;
    polls         = 0;
    read_word     = '0;
    cycle_cnt     = 0;
    void'($urandom(32'hb8b7));
    build_table();

    wait (local_rst == 1'b0);
    repeat (3) @(negedge CLK);
    assert ((bpi_status == 16'h8800) && (rbk_wrd_cnt == '0) && (seen_op.size() == 0))
    else
    begin
      $display("FAIL %0t: reset state wrong, status %h count %0d", $time, bpi_status,
               rbk_wrd_cnt);
      $display("Test failures found");
      $fatal(1, "check failed");
    end

    for (int e = 0; e < n_entries; e++)
      run_entry(e);

    // Bus protocol properties of the bound checker count here
    if (u_dut.u_assert.err_cnt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/bpi_ctrl_assert.sv
`timescale 1ns/10ps
`default_nettype none

module bpi_ctrl_assert
  import bpi_pkg::*;
(
  input wire logic        CLK,
  input wire logic        local_rst,
  input wire logic        bus_execute,
  input wire logic        bus_busy,
  input wire fifo_count_t rbk_wrd_cnt
);

  int unsigned err_cnt = 0;  // Failed properties so far

  // Execute is a single-cycle strobe
  a_exec_pulse: assert property (@(posedge CLK) disable iff (local_rst)
    bus_execute |=> !bus_execute)
    else
    begin
      $error("bus_execute held for more than one cycle");
      err_cnt++;
    end

  a_exec_not_busy: assert property (@(posedge CLK) disable iff (local_rst)
    bus_execute |-> !bus_busy)
    else
    begin
      $error("bus_execute issued while bus_busy high");
      err_cnt++;
    end

  a_rbk_count: assert property (@(posedge CLK) disable iff (local_rst)
    rbk_wrd_cnt <= fifo_count_t'(fifo_depth))
    else
    begin
      $error("readback word count above FIFO depth");
      err_cnt++;
    end

endmodule

bind bpi_ctrl bpi_ctrl_assert u_assert (
  .CLK         (CLK),
  .local_rst   (local_rst),
  .bus_execute (bus_execute),
  .bus_busy    (bus_busy),
  .rbk_wrd_cnt (rbk_wrd_cnt)
);

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
  output logic CLK,
  output logic local_rst
);

  initial
  begin
    CLK       = 1'b0;
    local_rst = 1'b1;
    repeat (3) @(posedge CLK);
    #2 local_rst = 1'b0;  // Released just after the third edge
  end

  always #20 CLK = ~CLK;  // 40 ns period

endmodule

`default_nettype wire

//--- source/bpi_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bpi_ctrl
  import bpi_pkg::*;
(
  input  wire logic         CLK,
  input  wire logic         local_rst,
  // Host side
  input  wire word_t        cmd_data,
  input  wire logic         cmd_we,
  input  wire logic         rbk_re,
  input  wire logic         parse_enable,
  input  wire logic         parse_disable,
  output word_t             rbk_data,
  output fifo_count_t       rbk_wrd_cnt,
  output word_t             bpi_status,
  // PROM bus side
  input  wire logic         bus_busy,
  input  wire logic         bus_load_data,
  input  wire word_t        bus_data_from,
  output logic              bus_execute,
  output bus_op_t           bus_op,
  output flash_addr_t       bus_addr,
  output word_t             bus_data_to
);

  cmd_word_t    cmd_head;
  logic         cmd_empty;
  logic         cmd_full;
  logic         cmd_wr_err;
  logic         cmd_rd_err;
  logic         cmd_pop;
  logic         rbk_empty;
  logic         rbk_full;
  logic         rbk_wr_err;
  logic         rbk_rd_err;
  logic         rbk_push;
  logic         op_start;
  logic         seq_idle;
  logic         clr_status;
  cmd_code_t    op_cmd;
  flash_addr_t  op_addr;
  word_t        op_data;
  logic [7:0]   sr_byte;

  //////////////////////////////////////////////////
  // Host to parser
  //////////////////////////////////////////////////
  bpi_word_fifo #(.item_t(cmd_word_t)) u_cmd_fifo (
    .CLK       (CLK),
    .local_rst (local_rst),
    .push      (cmd_we),
    .wdata     (cmd_word_t'(cmd_data)),
    .pop       (cmd_pop),
    .rdata     (cmd_head),
    .empty     (cmd_empty),
    .full      (cmd_full),
    .wr_err    (cmd_wr_err),
    .rd_err    (cmd_rd_err),
    .count     ()              // Host sees only the flags
  );

  bpi_cmd_parser u_parser (
    .CLK           (CLK),
    .local_rst     (local_rst),
    .parse_enable  (parse_enable),
    .parse_disable (parse_disable),
    .fifo_empty    (cmd_empty),
    .seq_idle      (seq_idle),
    .fifo_word     (cmd_head),
    .fifo_pop      (cmd_pop),
    .op_start      (op_start),
    .clr_status    (clr_status),
    .op_cmd        (op_cmd),
    .op_addr       (op_addr),
    .op_data       (op_data)
  );

  bpi_bus_sequencer u_sequencer (
    .CLK           (CLK),
    .local_rst     (local_rst),
    .op_start      (op_start),
    .bus_busy      (bus_busy),
    .bus_load_data (bus_load_data),
    .op_cmd        (op_cmd),
    .op_addr       (op_addr),
    .op_data       (op_data),
    .bus_data_from (bus_data_from),
    .seq_idle      (seq_idle),
    .bus_execute   (bus_execute),
    .rbk_push      (rbk_push),
    .bus_op        (bus_op),
    .bus_addr      (bus_addr),
    .bus_data_to   (bus_data_to),
    .sr_byte       (sr_byte)
  );

  //////////////////////////////////////////////////
  // Readback path and status
  //////////////////////////////////////////////////
  bpi_word_fifo #(.item_t(word_t)) u_rbk_fifo (
    .CLK       (CLK),
    .local_rst (local_rst),
    .push      (rbk_push),
    .wdata     (bus_data_from),
    .pop       (rbk_re),
    .rdata     (rbk_data),
    .empty     (rbk_empty),
    .full      (rbk_full),
    .wr_err    (rbk_wr_err),
    .rd_err    (rbk_rd_err),
    .count     (rbk_wrd_cnt)
  );

  bpi_status_reg u_status (
    .CLK        (CLK),
    .local_rst  (local_rst),
    .cmd_empty  (cmd_empty),
    .cmd_full   (cmd_full),
    .cmd_wr_err (cmd_wr_err),
    .cmd_rd_err (cmd_rd_err),
    .rbk_empty  (rbk_empty),
    .rbk_full   (rbk_full),
    .rbk_wr_err (rbk_wr_err),
    .rbk_rd_err (rbk_rd_err),
    .sr_byte    (sr_byte),
    .clr_status (clr_status),
    .bpi_status (bpi_status)
  );

endmodule

`default_nettype wire

//--- source/bpi_status_reg.sv
`timescale 1ns/10ps
`default_nettype none

module bpi_status_reg
  import bpi_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        local_rst,
  input  wire logic        cmd_empty,
  input  wire logic        cmd_full,
  input  wire logic        cmd_wr_err,
  input  wire logic        cmd_rd_err,
  input  wire logic        rbk_empty,
  input  wire logic        rbk_full,
  input  wire logic        rbk_wr_err,
  input  wire logic        rbk_rd_err,
  input  wire logic [7:0]  sr_byte,
  input  wire logic        clr_status,
  output word_t            bpi_status
);

  logic [7:0]  sr_last;
  logic        sr_new;

  assign sr_new = (sr_byte != sr_last);  // Fresh PROM status seen

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      bpi_status <= 16'h8800;  // Both FIFOs empty
      sr_last    <= '0;
    end
    else
    begin
      sr_last <= sr_byte;
      bpi_status[15]  <= rbk_empty;
      bpi_status[14]  <= rbk_full;
      bpi_status[13]  <= !clr_status && (bpi_status[13] || rbk_rd_err);
      bpi_status[12]  <= !clr_status && (bpi_status[12] || rbk_wr_err);
      bpi_status[11]  <= cmd_empty;
      bpi_status[10]  <= cmd_full;
      bpi_status[9]   <= !clr_status && (bpi_status[9] || cmd_rd_err);
      bpi_status[8]   <= !clr_status && (bpi_status[8] || cmd_wr_err);
      bpi_status[7:6] <= sr_byte[7:6];
      bpi_status[2]   <= sr_byte[2];
      bpi_status[0]   <= sr_byte[0];
      if (clr_status)
      begin
        bpi_status[5:3] <= 3'b000;
        bpi_status[1]   <= 1'b0;
      end
      else if (sr_new)
      begin
        bpi_status[5:3] <= sr_byte[5:3];  // Erase, program and Vpp errors
        bpi_status[1]   <= sr_byte[1];    // Block protection
      end
    end
  end

endmodule

`default_nettype wire

//--- sequencer/bpi_bus_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module bpi_bus_sequencer
  import bpi_pkg::*;
(
  input  wire logic         CLK,
  input  wire logic         local_rst,
  input  wire logic         op_start,
  input  wire logic         bus_busy,
  input  wire logic         bus_load_data,
  input  wire cmd_code_t    op_cmd,
  input  wire flash_addr_t  op_addr,
  input  wire word_t        op_data,
  input  wire word_t        bus_data_from,
  output logic              seq_idle,
  output logic              bus_execute,
  output logic              rbk_push,
  output bus_op_t           bus_op,
  output flash_addr_t       bus_addr,
  output word_t             bus_data_to,
  output logic [7:0]        sr_byte
);

  typedef enum logic [1:0] {s_idle, s_gap, s_wait} seq_state_t;

  seq_state_t  state;
  cmd_code_t   cur_cmd;
  word_t       cur_data;
  logic        phase2;     // Second write of erase or program sent
  logic        polling;
  logic        stat_mode;  // PROM reads return status
  logic        first_valid;
  bus_op_t     first_op;
  word_t       first_data;
  logic        pec_cmd;
  logic [7:0]  poll_stat;
  logic        wait_done;
  logic        issue_first;
  logic        issue_second;
  logic        issue_poll;

  always_comb
  begin
    first_valid = 1'b1;
    first_op    = bus_op_write;
    first_data  = '0;
    case (op_cmd)
      cmd_read_1:          first_op = bus_op_read;
      cmd_read_array:      first_data = read_array_code;
      cmd_read_status_reg: first_data = read_status_code;
      cmd_clr_status_reg:  first_data = clear_status_code;
      cmd_block_erase:     first_data = erase_setup_code;
      cmd_program:         first_data = program_setup_code;
      default:             first_valid = 1'b0;
    endcase
  end

  assign pec_cmd   = (cur_cmd == cmd_block_erase) || (cur_cmd == cmd_program);
  assign poll_stat = bus_load_data ? bus_data_from[7:0] : sr_byte;  // Data may land as busy drops
  assign wait_done = (state == s_wait) && !bus_busy;

  assign issue_first  = (state == s_idle) && op_start && first_valid;
  assign issue_second = wait_done && pec_cmd && !phase2;
  assign issue_poll   = wait_done && pec_cmd && phase2 &&
                        !(polling && poll_stat[sr_ready_bit]);

  assign seq_idle = (state == s_idle);
  assign rbk_push = bus_load_data && (cur_cmd == cmd_read_1);

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      state       <= s_idle;
      cur_cmd     <= cmd_noop;
      phase2      <= 1'b0;
      polling     <= 1'b0;
      stat_mode   <= 1'b0;
      sr_byte     <= '0;
      bus_execute <= 1'b0;
    end
    else
    begin
      bus_execute <= issue_first || issue_second || issue_poll;
      if (bus_load_data && stat_mode)
        sr_byte <= bus_data_from[7:0];
      if (issue_first)
      begin
        cur_cmd <= op_cmd;
        phase2  <= 1'b0;
        polling <= 1'b0;
        case (op_cmd)
          cmd_read_array:                                   stat_mode <= 1'b0;
          cmd_read_status_reg, cmd_block_erase, cmd_program: stat_mode <= 1'b1;
          default:                                          stat_mode <= stat_mode;
        endcase
      end
      if (issue_second)
        phase2 <= 1'b1;
      if (issue_poll)
        polling <= 1'b1;

      case (state)
        s_idle: if (issue_first) state <= s_gap;
        s_gap:  state <= s_wait;  // Let busy come up
        s_wait:
          if (issue_second || issue_poll)
            state <= s_gap;
          else if (wait_done)
            state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  // Bus fields hold until the next execute
  always_ff @(posedge CLK)
  begin
    if (issue_first)
    begin
      bus_op      <= first_op;
      bus_addr    <= op_addr;
      bus_data_to <= first_data;
      cur_data    <= op_data;
    end
    else if (issue_second)
      bus_data_to <= (cur_cmd == cmd_block_erase) ? confirm_code : cur_data;
    else if (issue_poll)
    begin
      bus_op   <= bus_op_read;
      bus_addr <= bus_addr & bank_mask;  // Status read at bank address
    end
  end

endmodule

`default_nettype wire

//--- parser/bpi_cmd_parser.sv
`timescale 1ns/10ps
`default_nettype none

module bpi_cmd_parser
  import bpi_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        local_rst,
  input  wire logic        parse_enable,
  input  wire logic        parse_disable,
  input  wire logic        fifo_empty,
  input  wire logic        seq_idle,
  input  wire cmd_word_t   fifo_word,
  output logic             fifo_pop,
  output logic             op_start,
  output logic             clr_status,
  output cmd_code_t        op_cmd,
  output flash_addr_t      op_addr,
  output word_t            op_data
);

  typedef enum logic [2:0] {p_idle, p_fetch, p_extra, p_issue, p_wait} parse_state_t;

  parse_state_t  state;
  logic          enabled;
  logic [6:0]    base_addr;
  logic [15:0]   offset;
  logic [10:0]   remain;     // Read_n words left, or base field of Load_Address
  cmd_code_t     cmd;
  word_t         prog_data;
  cmd_code_t     head_cmd;
  logic          needs_extra;
  logic          is_pass;
  flash_addr_t   waddr;
  flash_addr_t   block_addr;

  assign head_cmd    = cmd_code_t'(fifo_word.code);
  assign needs_extra = (head_cmd == cmd_load_address) || (head_cmd == cmd_program);
  assign is_pass     = (head_cmd == cmd_read_1) || (head_cmd == cmd_read_n) ||
                       (head_cmd == cmd_read_array) || (head_cmd == cmd_read_status_reg) ||
                       (head_cmd == cmd_clr_status_reg) || (head_cmd == cmd_block_erase);

  assign fifo_pop   = (state == p_fetch) || ((state == p_extra) && !fifo_empty);
  assign clr_status = (state == p_fetch) && (head_cmd == cmd_clr_bpi_status);
  assign op_start   = (state == p_issue);
  assign op_cmd     = (cmd == cmd_read_n) ? cmd_read_1 : cmd;  // Read_n runs as Read_1 ops
  assign op_data    = prog_data;

  //////////////////////////////////////////////////
  // Address selection
  //////////////////////////////////////////////////
  assign waddr = {base_addr, offset};

  always_comb
  begin
    if (waddr >= param_region_start)
      block_addr = waddr & param_block_mask;  // 16K parameter blocks
    else
      block_addr = waddr & main_block_mask;
  end

  always_comb
  begin
    case (cmd)
      cmd_block_erase:                     op_addr = block_addr;
      cmd_read_1, cmd_read_n, cmd_program: op_addr = waddr;
      default:                             op_addr = waddr & bank_mask;
    endcase
  end

  //////////////////////////////////////////////////
  // Parser FSM
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      state     <= p_idle;
      enabled   <= 1'b0;
      base_addr <= '0;
      offset    <= '0;
      remain    <= '0;
      cmd       <= cmd_noop;
    end
    else
    begin
      if (parse_enable)
        enabled <= 1'b1;
      else if (parse_disable)
        enabled <= 1'b0;

      case (state)
        p_idle:
          if (enabled && !fifo_empty)
            state <= p_fetch;
        p_fetch:
        begin
          cmd    <= head_cmd;
          remain <= fifo_word.arg;
          if (needs_extra)
            state <= p_extra;
          else if (is_pass)
            state <= p_issue;
          else
            state <= p_idle;  // Clr_BPI_Status or unknown code
        end
        p_extra:
          if (!fifo_empty)
          begin
            if (cmd == cmd_load_address)
            begin
              base_addr <= remain[6:0];
              offset    <= fifo_word;
              state     <= p_idle;
            end
            else
              state <= p_issue;  // Program data taken below
          end
        p_issue:
          state <= p_wait;
        p_wait:
          if (seq_idle)
          begin
            if ((cmd == cmd_read_1) || (cmd == cmd_read_n) || (cmd == cmd_program))
              offset <= offset + 1'b1;
            if ((cmd == cmd_read_n) && (remain != '0))
            begin
              remain <= remain - 1'b1;
              state  <= p_issue;
            end
            else
              state <= p_idle;
          end
        default:
          state <= p_idle;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if ((state == p_extra) && !fifo_empty)
      prog_data <= word_t'(fifo_word);
  end

endmodule

`default_nettype wire

//--- fifo/bpi_word_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module bpi_word_fifo
  import bpi_pkg::*;
#(
  parameter type item_t = word_t
)
(
  input  wire logic        CLK,
  input  wire logic        local_rst,
  input  wire logic        push,
  input  wire item_t       wdata,
  input  wire logic        pop,
  output item_t            rdata,
  output logic             empty,
  output logic             full,
  output logic             wr_err,
  output logic             rd_err,
  output fifo_count_t      count
);

  item_t                   mem [fifo_depth];
  logic [fifo_ptr_w-1:0]   wr_ptr;
  logic [fifo_ptr_w-1:0]   rd_ptr;
  logic                    push_ok;
  logic                    pop_ok;

  assign empty   = (count == '0);
  assign full    = (count == fifo_count_t'(fifo_depth));
  assign push_ok = push && !full;   // Overflow drops the word
  assign pop_ok  = pop && !empty;

  assign rdata = mem[rd_ptr];       // Head word shows without a pop

  always_ff @(posedge CLK)
  begin
    if (push_ok)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      wr_err <= 1'b0;
      rd_err <= 1'b0;
    end
    else
    begin
      wr_err <= push && full;
      rd_err <= pop && empty;
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at fifo_depth
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- common/bpi_pkg.sv
`default_nettype none

package bpi_pkg;

  //////////////////////////////////////////////////
  // Commands, low five bits of a command word
  //////////////////////////////////////////////////
  typedef enum logic [4:0] {
    cmd_noop            = 5'h00,
    cmd_read_1          = 5'h02,
    cmd_read_n          = 5'h04,
    cmd_read_array      = 5'h05,
    cmd_read_status_reg = 5'h06,
    cmd_clr_status_reg  = 5'h09,
    cmd_block_erase     = 5'h0A,
    cmd_program         = 5'h0B,
    cmd_load_address    = 5'h17,  // Local, not sent to PROM
    cmd_clr_bpi_status  = 5'h1C   // Local, not sent to PROM
  } cmd_code_t;

  typedef logic [15:0] word_t;

  // Count (Read_n) or base address (Load_Address) above the code
  typedef struct packed {
    logic [10:0] arg;
    logic [4:0]  code;
  } cmd_word_t;

  typedef logic [22:0] flash_addr_t;  // PROM word address

  typedef enum logic [1:0] {
    bus_op_write = 2'b01,
    bus_op_read  = 2'b10
  } bus_op_t;

  localparam int fifo_depth = 1024;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  typedef logic [fifo_ptr_w:0] fifo_count_t;

  //////////////////////////////////////////////////
  // PROM bus data codes
  //////////////////////////////////////////////////
  localparam word_t read_array_code    = 16'h00FF;
  localparam word_t read_status_code   = 16'h0070;
  localparam word_t clear_status_code  = 16'h0050;
  localparam word_t erase_setup_code   = 16'h0020;
  localparam word_t confirm_code       = 16'h00D0;
  localparam word_t program_setup_code = 16'h0040;

  // Bank, 64K main blocks, 16K parameter blocks at the top
  localparam flash_addr_t bank_mask          = 23'h780000;
  localparam flash_addr_t main_block_mask    = 23'h7F0000;
  localparam flash_addr_t param_block_mask   = 23'h7FC000;
  localparam flash_addr_t param_region_start = 23'h7F0000;

  // PROM status register
  localparam int         sr_ready_bit       = 7;
  localparam logic [7:0] erase_error_mask   = 8'h2A;
  localparam logic [7:0] program_error_mask = 8'h1A;

endpackage

`default_nettype wire
